/* src/apu_params.svh */
`ifndef APU_PARAMS_SVH
`define APU_PARAMS_SVH

// clk_100 cycles per sample strobe, kept short for simulation
`define APU_SAMPLE_DIV 64

`define APU_SAMPLE_W 24
`define APU_LEVEL_W  4
`define APU_FREQ_W   11

// APB bus carries byte-wide registers
`define APU_APB_AW 8
`define APU_APB_DW 8

`define APU_ADDR_NR10 8'h10
`define APU_ADDR_NR11 8'h11
`define APU_ADDR_NR12 8'h12
`define APU_ADDR_NR13 8'h13
`define APU_ADDR_NR14 8'h14
`define APU_ADDR_NR21 8'h16
`define APU_ADDR_NR22 8'h17
`define APU_ADDR_NR23 8'h18
`define APU_ADDR_NR24 8'h19
`define APU_ADDR_NR30 8'h1A
`define APU_ADDR_NR31 8'h1B
`define APU_ADDR_NR32 8'h1C
`define APU_ADDR_NR33 8'h1D
`define APU_ADDR_NR34 8'h1E
`define APU_ADDR_NR50 8'h24
`define APU_ADDR_NR51 8'h25
`define APU_ADDR_NR52 8'h26
`define APU_ADDR_WAVE 8'h30 // 16 bytes, up to 0x3F

`endif

/* src/apu_reg_pkg.sv */
`default_nettype none

`include "apu_params.svh"

package apu_reg_pkg;

    // square voice setup, from NR11..NR14 or NR21..NR24
    typedef struct packed {
        logic [1:0]             duty;   // NRx1[7:6]
        logic [3:0]             volume; // NRx2[7:4]
        logic [`APU_FREQ_W-1:0] freq;   // {NRx4[2:0], NRx3}
        logic                   enable;
    } square_regs_t;

    // wave voice setup, NR30..NR34
    typedef struct packed {
        logic                   dac_en;   // NR30[7]
        logic [1:0]             vol_code; // NR32[6:5]
        logic [`APU_FREQ_W-1:0] freq;
        logic                   enable;
    } wave_regs_t;

    // master volume and panning
    typedef struct packed {
        logic [2:0] vol_l; // NR50[6:4]
        logic [2:0] vol_r; // NR50[2:0]
        logic [7:0] pan;   // NR51, left in the high nibble
    } mix_regs_t;

endpackage

`default_nettype wire

/* src/apu_audio_pkg.sv */
`default_nettype none

`include "apu_params.svh"

package apu_audio_pkg;

    typedef logic [`APU_LEVEL_W-1:0]  level_t;  // raw voice output
    typedef logic [`APU_SAMPLE_W-1:0] sample_t; // codec word

    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_t;

    // one-hot source select, noise bit kept for the missing voice
    typedef struct packed {
        logic mix;
        logic noise;
        logic wav;
        logic sq2;
        logic sq1;
    } source_t;

endpackage

`default_nettype wire

/* src/apu_regs.sv */
`default_nettype none

`include "apu_params.svh"

module apu_regs (
    input  wire                       clk_100,
    input  wire                       arst_n,
    input  wire [`APU_APB_AW-1:0]     paddr,
    input  wire                       psel,
    input  wire                       penable,
    input  wire                       pwrite,
    input  wire [`APU_APB_DW-1:0]     pwdata,
    output logic [`APU_APB_DW-1:0]    prdata,
    output logic                      pready,
    output logic                      pslverr,
    output apu_reg_pkg::square_regs_t sq1_regs,
    output apu_reg_pkg::square_regs_t sq2_regs,
    output apu_reg_pkg::wave_regs_t   wav_regs,
    output logic [127:0]              wave_ram,
    output apu_reg_pkg::mix_regs_t    mix_regs,
    output logic                      sq1_trig,
    output logic                      sq2_trig,
    output logic                      wav_trig,
    output logic                      power
);
    // everything that power-off clears, NR52 lives outside
    typedef struct packed {
        logic [7:0] nr10, nr11, nr12, nr13, nr14;
        logic [7:0] nr21, nr22, nr23, nr24;
        logic [7:0] nr30, nr31, nr32, nr33, nr34;
        logic [7:0] nr50, nr51;
    } bank_t;

    bank_t      bank;
    logic [7:0] nr52;
    logic       sq1_on, sq2_on, wav_on; // set by trigger
    logic       access;
    logic       is_wave;
    logic       nr52_sel;
    logic       mapped;
    logic       wr_en;
    logic       sq1_hit, sq2_hit, wav_hit;

    assign access   = psel && penable;
    assign is_wave  = (paddr[7:4] == 4'(`APU_ADDR_WAVE >> 4));
    assign nr52_sel = (paddr == `APU_ADDR_NR52);
    assign power    = nr52[7];
    assign pready   = 1'b1; // no wait states

    // with power off only NR52 accepts writes
    assign wr_en   = access && pwrite && mapped && (power || nr52_sel);
    assign pslverr = access && (!mapped || (pwrite && !power && !nr52_sel));

    assign sq1_hit = wr_en && (paddr == `APU_ADDR_NR14) && pwdata[7];
    assign sq2_hit = wr_en && (paddr == `APU_ADDR_NR24) && pwdata[7];
    assign wav_hit = wr_en && (paddr == `APU_ADDR_NR34) && pwdata[7];

    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            `APU_ADDR_NR10: prdata = bank.nr10;
            `APU_ADDR_NR11: prdata = bank.nr11;
            `APU_ADDR_NR12: prdata = bank.nr12;
            `APU_ADDR_NR13: prdata = bank.nr13;
            `APU_ADDR_NR14: prdata = bank.nr14;
            `APU_ADDR_NR21: prdata = bank.nr21;
            `APU_ADDR_NR22: prdata = bank.nr22;
            `APU_ADDR_NR23: prdata = bank.nr23;
            `APU_ADDR_NR24: prdata = bank.nr24;
            `APU_ADDR_NR30: prdata = bank.nr30;
            `APU_ADDR_NR31: prdata = bank.nr31;
            `APU_ADDR_NR32: prdata = bank.nr32;
            `APU_ADDR_NR33: prdata = bank.nr33;
            `APU_ADDR_NR34: prdata = bank.nr34;
            `APU_ADDR_NR50: prdata = bank.nr50;
            `APU_ADDR_NR51: prdata = bank.nr51;
            `APU_ADDR_NR52: prdata = nr52;
            default: begin
                mapped = is_wave;
                if (is_wave) prdata = wave_ram[{paddr[3:0], 3'b000} +: 8];
            end
        endcase
    end

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            bank     <= '0;
            nr52     <= '0;
            wave_ram <= '0;
            sq1_on   <= 1'b0;
            sq2_on   <= 1'b0;
            wav_on   <= 1'b0;
            sq1_trig <= 1'b0;
            sq2_trig <= 1'b0;
            wav_trig <= 1'b0;
        end else begin
            sq1_trig <= sq1_hit; // one cycle after the access phase
            sq2_trig <= sq2_hit;
            wav_trig <= wav_hit;
            if (sq1_hit) sq1_on <= 1'b1;
            if (sq2_hit) sq2_on <= 1'b1;
            if (wav_hit) wav_on <= 1'b1;
            if (wr_en) begin
                case (paddr)
                    `APU_ADDR_NR10: bank.nr10 <= pwdata;
                    `APU_ADDR_NR11: bank.nr11 <= pwdata;
                    `APU_ADDR_NR12: bank.nr12 <= pwdata;
                    `APU_ADDR_NR13: bank.nr13 <= pwdata;
                    `APU_ADDR_NR14: bank.nr14 <= pwdata;
                    `APU_ADDR_NR21: bank.nr21 <= pwdata;
                    `APU_ADDR_NR22: bank.nr22 <= pwdata;
                    `APU_ADDR_NR23: bank.nr23 <= pwdata;
                    `APU_ADDR_NR24: bank.nr24 <= pwdata;
                    `APU_ADDR_NR30: bank.nr30 <= pwdata;
                    `APU_ADDR_NR31: bank.nr31 <= pwdata;
                    `APU_ADDR_NR32: bank.nr32 <= pwdata;
                    `APU_ADDR_NR33: bank.nr33 <= pwdata;
                    `APU_ADDR_NR34: bank.nr34 <= pwdata;
                    `APU_ADDR_NR50: bank.nr50 <= pwdata;
                    `APU_ADDR_NR51: bank.nr51 <= pwdata;
                    `APU_ADDR_NR52: nr52 <= pwdata;
                    default: wave_ram[{paddr[3:0], 3'b000} +: 8] <= pwdata;
                endcase
            end
            // power off holds the rest of the unit cleared
            if (!power) begin
                bank     <= '0;
                wave_ram <= '0;
                sq1_on   <= 1'b0;
                sq2_on   <= 1'b0;
                wav_on   <= 1'b0;
            end
        end
    end

    assign sq1_regs = '{duty: bank.nr11[7:6], volume: bank.nr12[7:4],
                        freq: {bank.nr14[2:0], bank.nr13}, enable: sq1_on};
    assign sq2_regs = '{duty: bank.nr21[7:6], volume: bank.nr22[7:4],
                        freq: {bank.nr24[2:0], bank.nr23}, enable: sq2_on};
    assign wav_regs = '{dac_en: bank.nr30[7], vol_code: bank.nr32[6:5],
                        freq: {bank.nr34[2:0], bank.nr33}, enable: wav_on};
    assign mix_regs = '{vol_l: bank.nr50[6:4], vol_r: bank.nr50[2:0], pan: bank.nr51};

endmodule

`default_nettype wire

/* src/square_channel.sv */
`default_nettype none

`include "apu_params.svh"

module square_channel (
    input  wire                            clk_100,
    input  wire                            arst_n,
    input  wire                            sample_tick,
    input  wire                            power,
    input  wire                            trig,
    input  wire apu_reg_pkg::square_regs_t regs,
    output apu_audio_pkg::level_t          level
);
    logic [`APU_FREQ_W-1:0] timer;      // strobes spent on this step
    logic [`APU_FREQ_W-1:0] timer_base;
    logic [2:0]             pos;        // duty position
    logic [2:0]             pos_now;
    logic [7:0]             pattern;
    logic                   step_done;

    always_comb begin
        case (regs.duty)
            2'd0:    pattern = 8'b0000_0001; // 1 of 8
            2'd1:    pattern = 8'b1000_0001; // 2 of 8
            2'd2:    pattern = 8'b1000_0111; // 4 of 8
            default: pattern = 8'b0111_1110; // 6 of 8
        endcase
    end

    // a trigger shows step zero in the same cycle
    assign pos_now    = trig ? 3'd0 : pos;
    assign timer_base = trig ? '0 : timer;

    // period is 2048 - freq, so the last count is ~freq
    assign step_done = sample_tick && (timer_base >= ~regs.freq);

    assign level = (power && regs.enable && pattern[pos_now]) ? regs.volume : '0;

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            timer <= '0;
            pos   <= '0;
        end else if (!power) begin
            timer <= '0;
            pos   <= '0;
        end else if (trig || sample_tick) begin
            if (step_done) begin
                timer <= '0;
                pos   <= pos_now + 3'd1;
            end else begin
                timer <= timer_base + (`APU_FREQ_W)'(sample_tick);
                pos   <= pos_now;
            end
        end
    end

endmodule

`default_nettype wire

/* src/wave_channel.sv */
`default_nettype none

`include "apu_params.svh"

module wave_channel (
    input  wire                          clk_100,
    input  wire                          arst_n,
    input  wire                          sample_tick,
    input  wire                          power,
    input  wire                          trig,
    input  wire apu_reg_pkg::wave_regs_t regs,
    input  wire [127:0]                  wave_ram,
    output apu_audio_pkg::level_t        level
);
    import apu_audio_pkg::*;

    logic [`APU_FREQ_W-1:0] timer;
    logic [`APU_FREQ_W-1:0] timer_base;
    logic [4:0]             pos;      // nibble index into the RAM
    logic [4:0]             pos_now;
    logic                   step_done;
    level_t                 nibble;
    level_t                 shifted;

    assign pos_now    = trig ? 5'd0 : pos;
    assign timer_base = trig ? '0 : timer;
    assign step_done  = sample_tick && (timer_base >= ~regs.freq);

    // high nibble of each byte plays first
    assign nibble = wave_ram[{pos_now[4:1], ~pos_now[0], 2'b00} +: 4];

    always_comb begin
        case (regs.vol_code)
            2'd0:    shifted = '0;          // mute
            2'd1:    shifted = nibble;
            2'd2:    shifted = nibble >> 1;
            default: shifted = nibble >> 2;
        endcase
    end

    assign level = (power && regs.dac_en && regs.enable) ? shifted : '0;

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            timer <= '0;
            pos   <= '0;
        end else if (!power) begin
            timer <= '0;
            pos   <= '0;
        end else if (trig || sample_tick) begin
            if (step_done) begin
                timer <= '0;
                pos   <= pos_now + 5'd1; // wraps after 32 nibbles
            end else begin
                timer <= timer_base + (`APU_FREQ_W)'(sample_tick);
                pos   <= pos_now;
            end
        end
    end

endmodule

`default_nettype wire

/* src/channel_mixer.sv */
`default_nettype none

module channel_mixer (
    input  wire                         clk_100,
    input  wire                         arst_n,
    input  wire                         sample_tick,
    input  wire apu_audio_pkg::level_t  sq1_level,
    input  wire apu_audio_pkg::level_t  sq2_level,
    input  wire apu_audio_pkg::level_t  wav_level,
    input  wire apu_reg_pkg::mix_regs_t regs,
    output apu_audio_pkg::stereo_t      mix
);
    import apu_audio_pkg::*;

    logic [5:0] sum_l;  // up to 3 x 15
    logic [5:0] sum_r;
    logic [9:0] amp_l;  // sum x 8 at most
    logic [9:0] amp_r;

    // adds the voices whose pan bit is set, bit 0 is square 1
    function automatic logic [5:0] pan_sum(input logic [2:0] sel, input level_t a,
                                           input level_t b, input level_t c);
        logic [5:0] acc;
        acc = '0;
        if (sel[0]) acc = acc + 6'(a);
        if (sel[1]) acc = acc + 6'(b);
        if (sel[2]) acc = acc + 6'(c);
        return acc;
    endfunction

    // sums are taken on the strobe, so mix trails the voices by one sample
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            sum_l <= '0;
            sum_r <= '0;
        end else if (sample_tick) begin
            sum_l <= pan_sum(regs.pan[6:4], sq1_level, sq2_level, wav_level);
            sum_r <= pan_sum(regs.pan[2:0], sq1_level, sq2_level, wav_level);
        end
    end

    assign amp_l = 10'(sum_l) * (10'(regs.vol_l) + 10'd1);
    assign amp_r = 10'(sum_r) * (10'(regs.vol_r) + 10'd1);

    // result sits in bits 23..14
    assign mix = '{left: {amp_l, 14'd0}, right: {amp_r, 14'd0}};

endmodule

`default_nettype wire

/* src/sample_select.sv */
`default_nettype none

`include "apu_params.svh"

module sample_select (
    input  wire                          clk_100,
    input  wire                          arst_n,
    input  wire apu_audio_pkg::source_t  source,
    input  wire apu_audio_pkg::level_t   sq1_level,
    input  wire apu_audio_pkg::level_t   sq2_level,
    input  wire apu_audio_pkg::level_t   wav_level,
    input  wire apu_audio_pkg::stereo_t  mix,
    output logic                         sample_tick,
    output apu_audio_pkg::stereo_t       sample_out,
    output logic                         sample_valid
);
    import apu_audio_pkg::*;

    localparam int DIV_W = $clog2(`APU_SAMPLE_DIV);

    logic [DIV_W-1:0] div_cnt;
    logic [5:0]       saw;     // test ramp
    logic [4:0]       src_bits;
    logic             src_ok;

    // a single voice goes to both sides in bits 23..20
    function automatic stereo_t mono(input level_t lvl);
        sample_t s;
        s = {lvl, 20'd0};
        return '{left: s, right: s};
    endfunction

    assign src_bits    = source;
    assign src_ok      = $onehot(src_bits);
    assign sample_tick = (div_cnt == DIV_W'(`APU_SAMPLE_DIV - 1));

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt      <= '0;
            saw          <= '0;
            sample_valid <= 1'b0;
        end else begin
            div_cnt      <= sample_tick ? '0 : div_cnt + 1'b1;
            sample_valid <= sample_tick;
            if (sample_tick && !src_ok) saw <= saw + 6'd1;
        end
    end

    always_ff @(posedge clk_100) begin
        if (sample_tick) begin
            case (src_bits)
                5'b00001: sample_out <= mono(sq1_level);
                5'b00010: sample_out <= mono(sq2_level);
                5'b00100: sample_out <= mono(wav_level);
                5'b01000: sample_out <= '0;  // no noise voice, silence
                5'b10000: sample_out <= mix;
                default:  sample_out <= '{left: {saw, 18'd0}, right: {saw, 18'd0}};
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/apu_top.sv */
`default_nettype none

`include "apu_params.svh"

module apu_top (
    input  wire                          clk_100,
    input  wire                          arst_n,
    input  wire [`APU_APB_AW-1:0]        paddr,
    input  wire                          psel,
    input  wire                          penable,
    input  wire                          pwrite,
    input  wire [`APU_APB_DW-1:0]        pwdata,
    output logic [`APU_APB_DW-1:0]       prdata,
    output logic                         pready,
    output logic                         pslverr,
    input  wire apu_audio_pkg::source_t  source,
    output apu_audio_pkg::stereo_t       sample_out,
    output logic                         sample_valid
);
    import apu_reg_pkg::*;
    import apu_audio_pkg::*;

    square_regs_t sq1_regs;
    square_regs_t sq2_regs;
    wave_regs_t   wav_regs;
    mix_regs_t    mix_regs;
    logic [127:0] wave_ram;
    logic         sq1_trig, sq2_trig, wav_trig;
    logic         power;
    logic         sample_tick;
    level_t       sq1_level, sq2_level, wav_level;
    stereo_t      mix;

    apu_regs regs0 (
        .clk_100, .arst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr, .sq1_regs, .sq2_regs, .wav_regs,
        .wave_ram, .mix_regs, .sq1_trig, .sq2_trig, .wav_trig, .power
    );

    square_channel sq1 (
        .clk_100, .arst_n, .sample_tick, .power,
        .trig(sq1_trig), .regs(sq1_regs), .level(sq1_level)
    );

    square_channel sq2 (
        .clk_100, .arst_n, .sample_tick, .power,
        .trig(sq2_trig), .regs(sq2_regs), .level(sq2_level)
    );

    wave_channel wav (
        .clk_100, .arst_n, .sample_tick, .power,
        .trig(wav_trig), .regs(wav_regs), .wave_ram, .level(wav_level)
    );

    channel_mixer mixer0 (
        .clk_100, .arst_n, .sample_tick, .sq1_level, .sq2_level, .wav_level,
        .regs(mix_regs), .mix
    );

    sample_select sel0 (
        .clk_100, .arst_n, .source, .sq1_level, .sq2_level, .wav_level,
        .mix, .sample_tick, .sample_out, .sample_valid
    );

endmodule

`default_nettype wire

/* tests/apu_checker.sv */
`default_nettype none

module apu_checker (
    input wire clk_100,
    input wire arst_n,
    input wire psel,
    input wire penable,
    input wire sample_tick,
    input wire sample_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    // setup phase must be followed by the access phase
    a_enable_follows_select: assert property (
        @(posedge clk_100) disable iff (!arst_n) psel && !penable |=> psel && penable
    ) else $error("APB penable did not follow psel");

    a_enable_needs_select: assert property (
        @(posedge clk_100) disable iff (!arst_n) penable |-> psel
    ) else $error("APB penable high without psel");

    a_valid_single: assert property (
        @(posedge clk_100) disable iff (!arst_n) sample_valid |=> !sample_valid
    ) else $error("sample_valid high for two cycles");

    a_valid_after_tick: assert property (
        @(posedge clk_100) disable iff (!arst_n) sample_tick |=> sample_valid
    ) else $error("sample_valid missing one cycle after sample_tick");

    a_valid_from_tick: assert property (
        @(posedge clk_100) disable iff (!arst_n) sample_valid |-> $past(sample_tick)
    ) else $error("sample_valid without a preceding sample_tick");

endmodule

// one instance sees both the bus and the sample stream
bind apu_top apu_checker chk (
    .clk_100(clk_100), .arst_n(arst_n), .psel(psel), .penable(penable),
    .sample_tick(sample_tick), .sample_valid(sample_valid)
);

`default_nettype wire

/* tests/apu_tb.sv */
`default_nettype none

`include "apu_params.svh"

module apu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import apu_audio_pkg::*;

    localparam int CLK_NS     = 4;
    localparam int SQ_WINDOWS = 2;
    localparam int WAVE_N     = 120;
    localparam int MIX_N      = 64;
    localparam int SAW_N      = 70;
    localparam int ZERO_N     = 4;
    // square runs, wave, mix, ramp, power sources, plus APB traffic
    localparam int TEST_SAMPLES = 8 * (SQ_WINDOWS * 64 + 3) + WAVE_N + MIX_N + SAW_N
                                  + 4 * (ZERO_N + 3) + 60;
    localparam int WATCHDOG_NS  = TEST_SAMPLES * `APU_SAMPLE_DIV * CLK_NS + 20000;

    localparam int M_SQ   = 1;
    localparam int M_WAV  = 2;
    localparam int M_MIX  = 3;
    localparam int M_ZERO = 4;
    localparam int M_SAW  = 5;

    logic                   clk_100;
    logic                   arst_n;
    logic [`APU_APB_AW-1:0] paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`APU_APB_DW-1:0] pwdata;
    logic [`APU_APB_DW-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
    source_t                source;
    stereo_t                sample_out;
    logic                   sample_valid;

    int         seed;
    int         errors;
    bit         check_on;
    int         mode;
    int         samp_k;      // samples since the trigger or arm point
    int         high_cnt;
    int         acc_l;
    int         acc_r;
    int         sq_ch;
    int         sq_period;
    logic [1:0] duty_of [2];
    logic [3:0] vol_of [2];
    int         wav_period;
    logic [10:0] wav_freq;
    logic [1:0] wav_code;
    logic [7:0] wave_mem [16];
    logic [7:0] mix_pan;
    logic [2:0] vol_l;
    logic [2:0] vol_r;
    logic [5:0] saw_base;
    logic [7:0] reg_addr [17];

    apu_top dut0 (
        .clk_100, .arst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr, .source, .sample_out, .sample_valid
    );

    initial begin
        clk_100 = 1'b0;
        forever #(CLK_NS / 2) clk_100 = ~clk_100;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    function automatic int duty_highs(input logic [1:0] duty);
        case (duty)
            2'd0:    return 1;
            2'd1:    return 2;
            2'd2:    return 4;
            default: return 6;
        endcase
    endfunction

    // nibble k of the wave voice with the high nibble of a byte first
    function automatic level_t wave_level(input int k);
        int         pos;
        logic [7:0] b;
        level_t     n;
        pos = (k / wav_period) % 32;
        b   = wave_mem[pos / 2];
        n   = (pos % 2 == 0) ? b[7:4] : b[3:0];
        case (wav_code)
            2'd0:    n = '0;
            2'd1:    n = n;
            2'd2:    n = n >> 1;
            default: n = n >> 2;
        endcase
        return n;
    endfunction

    // expected sample k with the high value for squares
    function automatic stereo_t ref_sample(input int k);
        level_t  lvl;
        sample_t s;
        stereo_t r;
        lvl = '0;
        if (mode == M_SQ) lvl = vol_of[sq_ch];
        else if (mode == M_WAV) lvl = wave_level(k);
        s = {lvl, 20'd0};
        if (mode == M_SAW) s = {saw_base + 6'(k), 18'd0};
        r.left  = s;
        r.right = s;
        return r;
    endfunction

    // one side summed over mix samples k_first..k_first+7 from levels one sample earlier
    function automatic int mix_expect(input int k_first, input logic [2:0] pan,
                                      input logic [2:0] vol);
        int lv;
        int j;
        lv = 0;
        if (pan[0]) lv += duty_highs(duty_of[0]) * int'(vol_of[0]);
        if (pan[1]) lv += duty_highs(duty_of[1]) * int'(vol_of[1]);
        if (pan[2]) begin
            for (j = k_first - 1; j < k_first + 7; j++) lv += int'(wave_level(j));
        end
        return lv * (int'(vol) + 1);
    endfunction

    always @(negedge clk_100) begin
        if (sample_valid && check_on) begin
            case (mode)
                M_SQ: begin
                    if (sample_out != '0) begin
                        check_equal("sample_out", sample_out, ref_sample(samp_k));
                        high_cnt++;
                    end
                    if ((samp_k + 1) % (8 * sq_period) == 0) begin
                        check_equal("square high samples", high_cnt,
                                    duty_highs(duty_of[sq_ch]) * sq_period);
                        high_cnt = 0;
                    end
                end
                M_MIX: if (samp_k > 0) begin
                    check_equal("sample_out low bits",
                                {sample_out.left[13:0], sample_out.right[13:0]}, '0);
                    acc_l += int'(sample_out.left[23:14]);
                    acc_r += int'(sample_out.right[23:14]);
                    if (samp_k % 8 == 0) begin
                        check_equal("mix left sum", acc_l,
                                    mix_expect(samp_k - 7, mix_pan[6:4], vol_l));
                        check_equal("mix right sum", acc_r,
                                    mix_expect(samp_k - 7, mix_pan[2:0], vol_r));
                        acc_l = 0;
                        acc_r = 0;
                    end
                end
                default: begin
                    if (mode == M_SAW && samp_k == 0) saw_base = sample_out.left[23:18];
                    check_equal("sample_out", sample_out, ref_sample(samp_k));
                end
            endcase
            samp_k++;
        end
    end

    task automatic apb_xfer(input logic wr, input logic [7:0] a, input logic [7:0] d,
                            output logic [7:0] rd, output logic err);
        @(posedge clk_100);
        #1;
        paddr   = a;
        pwdata  = d;
        pwrite  = wr;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk_100);
        #1;
        penable = 1'b1;
        @(negedge clk_100);
        check_equal("pready", pready, 1'b1); // no wait states on this bus
        while (!pready) @(negedge clk_100);
        rd  = prdata;
        err = pslverr;
        @(posedge clk_100);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] a, input logic [7:0] d, input logic exp_err);
        logic [7:0] rd;
        logic       err;
        apb_xfer(1'b1, a, d, rd, err);
        check_equal($sformatf("pslverr on write %02h", a), err, exp_err);
    endtask

    task automatic read_check(input logic [7:0] a, input logic [7:0] exp, input logic exp_err);
        logic [7:0] rd;
        logic       err;
        apb_xfer(1'b0, a, 8'h00, rd, err);
        check_equal($sformatf("pslverr on read %02h", a), err, exp_err);
        if (!exp_err) check_equal($sformatf("prdata@%02h", a), rd, exp);
    endtask

    task automatic wait_valid();
        @(negedge clk_100);
        while (!sample_valid) @(negedge clk_100);
    endtask

    task automatic arm(input int m);
        mode     = m;
        samp_k   = 0;
        high_cnt = 0;
        acc_l    = 0;
        acc_r    = 0;
        check_on = 1'b1;
    endtask

    task automatic collect(input int n);
        while (samp_k < n) @(posedge clk_100);
        #1;
        check_on = 1'b0;
    endtask

    task automatic register_test();
        logic [7:0] vals [17];
        logic [7:0] wav [16];
        int         i;
        vals[16] = 8'h80 | 8'($random(seed)); // keep power on
        write_reg(`APU_ADDR_NR52, vals[16], 1'b0);
        for (i = 0; i < 16; i++) begin
            vals[i] = 8'($random(seed));
            write_reg(reg_addr[i], vals[i], 1'b0);
        end
        for (i = 0; i < 16; i++) begin
            wav[i] = 8'($random(seed));
            write_reg(`APU_ADDR_WAVE + 8'(i), wav[i], 1'b0);
        end
        for (i = 0; i < 17; i++) read_check(reg_addr[i], vals[i], 1'b0);
        for (i = 0; i < 16; i++) read_check(`APU_ADDR_WAVE + 8'(i), wav[i], 1'b0);
        read_check(8'h00, 8'h00, 1'b1); // unmapped
        read_check(8'h15, 8'h00, 1'b1);
        read_check(8'h27, 8'h00, 1'b1);
    endtask

    task automatic square_test(input int ch);
        logic [7:0]  base;
        logic [10:0] freq;
        int          d;
        base   = (ch == 1) ? `APU_ADDR_NR21 : `APU_ADDR_NR11;
        source = (ch == 1) ? 5'b00010 : 5'b00001;
        sq_ch  = ch;
        for (d = 0; d < 4; d++) begin
            freq        = 11'd2040 + 11'($random(seed) & 7); // period 1..8
            sq_period   = 2048 - int'(freq);
            duty_of[ch] = 2'(d);
            vol_of[ch]  = 4'($random(seed));
            if (vol_of[ch] == 4'd0) vol_of[ch] = 4'd15;
            write_reg(base, {duty_of[ch], 6'h2a}, 1'b0);
            write_reg(base + 8'd1, {vol_of[ch], 4'h3}, 1'b0);
            write_reg(base + 8'd2, freq[7:0], 1'b0);
            wait_valid();
            write_reg(base + 8'd3, {5'b10000, freq[10:8]}, 1'b0); // trigger
            arm(M_SQ);
            collect(SQ_WINDOWS * 8 * sq_period);
        end
    endtask

    task automatic wave_test();
        int i;
        for (i = 0; i < 16; i++) begin
            wave_mem[i] = 8'($random(seed));
            write_reg(`APU_ADDR_WAVE + 8'(i), wave_mem[i], 1'b0);
        end
        wav_freq   = 11'd2045 + 11'(($random(seed) & 32'h7fff_ffff) % 3);
        wav_period = 2048 - int'(wav_freq);
        wav_code   = 2'd1 + 2'(($random(seed) & 32'h7fff_ffff) % 3);
        write_reg(`APU_ADDR_NR30, 8'h80, 1'b0); // DAC on
        write_reg(`APU_ADDR_NR32, {1'b0, wav_code, 5'd0}, 1'b0);
        write_reg(`APU_ADDR_NR33, wav_freq[7:0], 1'b0);
        source = 5'b00100;
        wait_valid();
        write_reg(`APU_ADDR_NR34, {5'b10000, wav_freq[10:8]}, 1'b0);
        arm(M_WAV);
        collect(WAVE_N);
    endtask

    // squares at period 1 give one full duty cycle per 8 samples
    task automatic mix_test();
        logic [7:0] base;
        logic [7:0] nr50;
        int         ch;
        for (ch = 0; ch < 2; ch++) begin
            base        = (ch == 1) ? `APU_ADDR_NR21 : `APU_ADDR_NR11;
            duty_of[ch] = 2'($random(seed));
            vol_of[ch]  = 4'($random(seed));
            write_reg(base, {duty_of[ch], 6'h00}, 1'b0);
            write_reg(base + 8'd1, {vol_of[ch], 4'h0}, 1'b0);
            write_reg(base + 8'd2, 8'hff, 1'b0);
            write_reg(base + 8'd3, 8'h87, 1'b0);
        end
        mix_pan = 8'($random(seed));
        nr50    = 8'($random(seed));
        vol_l   = nr50[6:4];
        vol_r   = nr50[2:0];
        write_reg(`APU_ADDR_NR50, nr50, 1'b0);
        write_reg(`APU_ADDR_NR51, mix_pan, 1'b0);
        source = 5'b10000;
        wait_valid();
        write_reg(`APU_ADDR_NR34, {5'b10000, wav_freq[10:8]}, 1'b0); // restart wave
        arm(M_MIX);
        collect(MIX_N);
    endtask

    task automatic saw_test();
        source = 5'b00011; // two bits set so not one-hot
        wait_valid();
        @(posedge clk_100);
        #1;
        arm(M_SAW);
        collect(SAW_N);
    endtask

    task automatic power_test();
        int i;
        write_reg(`APU_ADDR_NR52, 8'h00, 1'b0);
        for (i = 0; i < 17; i++) read_check(reg_addr[i], 8'h00, 1'b0);
        for (i = 0; i < 16; i++) read_check(`APU_ADDR_WAVE + 8'(i), 8'h00, 1'b0);
        write_reg(`APU_ADDR_NR12, 8'hf0, 1'b1);
        read_check(`APU_ADDR_NR12, 8'h00, 1'b0);
        for (i = 0; i < 4; i++) begin
            source = (i == 3) ? 5'b10000 : 5'(1 << i);
            wait_valid();
            @(posedge clk_100);
            #1;
            arm(M_ZERO);
            collect(ZERO_N);
        end
    endtask

    initial begin
        seed     = 80663;
        errors   = 0;
        check_on = 1'b0;
        mode     = 0;
        samp_k   = 0;
        arst_n   = 1'b0;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;
        source   = 5'b00001;
        reg_addr = '{`APU_ADDR_NR10, `APU_ADDR_NR11, `APU_ADDR_NR12, `APU_ADDR_NR13,
                     `APU_ADDR_NR14, `APU_ADDR_NR21, `APU_ADDR_NR22, `APU_ADDR_NR23,
                     `APU_ADDR_NR24, `APU_ADDR_NR30, `APU_ADDR_NR31, `APU_ADDR_NR32,
                     `APU_ADDR_NR33, `APU_ADDR_NR34, `APU_ADDR_NR50, `APU_ADDR_NR51,
                     `APU_ADDR_NR52};
        repeat (4) @(posedge clk_100);
        #1;
        arst_n = 1'b1;

        register_test();
        square_test(0);
        square_test(1);
        wave_test();
        mix_test();
        saw_test();
        power_test(); // leaves the unit powered down

        $display("tests done, %0d errors", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+src
src/apu_reg_pkg.sv
src/apu_audio_pkg.sv
src/apu_regs.sv
src/square_channel.sv
src/wave_channel.sv
src/channel_mixer.sv
src/sample_select.sv
src/apu_top.sv
tests/apu_checker.sv
tests/apu_tb.sv

/* Makefile */
TOP := apu_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /SIMULATION PASSED/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
